// File: common/motoro3_cfg.svh
`ifndef MOTORO3_CFG_SVH
`define MOTORO3_CFG_SVH

// pwm period length in clk cycles
`define PWM_PERIOD 64

// shortest pulse the MOSFET stage can follow
`define MIN_PULSE 8

// whole pwm periods per commutation step
`define STEP_PERIODS 4

// width of pulse lengths and remainders
`define PULSE_W 16

// counter widths, period counter, period-in-step counter, pulse timer
`define PERIOD_CNT_W 6
`define STEP_CNT_W 2
`define PULSE_CNT_W 7

`endif

// File: common/motoro3_pkg.sv
`default_nettype none

`include "motoro3_cfg.svh"

package motoro3_pkg;

    // twelve half-steps per electrical turn
    localparam int unsigned STEP_COUNT = 12;

    // commutation step index, 0 to 11
    typedef logic [3:0] stepIdx_t;

    localparam stepIdx_t LAST_STEP = stepIdx_t'(STEP_COUNT - 1);

    // pulse length or carried remainder
    typedef logic [`PULSE_W-1:0] pulseLen_t;

    // want/real cycle accumulator
    typedef logic [15:0] accum_t;

    typedef enum logic [1:0] {
        PHASE_A,
        PHASE_B,
        PHASE_C
    } phase_e;

    // step on which a phase may be pulled up by its partner
    function automatic stepIdx_t forceStep(phase_e phase);
        case (phase)
            PHASE_A: return stepIdx_t'(1);
            PHASE_B: return stepIdx_t'(6);
            default: return stepIdx_t'(11);
        endcase
    endfunction

endpackage

`default_nettype wire

// File: common/stepTiming_if.sv
`default_nettype none

interface stepTiming_if;
    import motoro3_pkg::*;

    // current commutation step
    stepIdx_t step;

    // single-cycle strobes, no back-pressure
    logic stepStart;
    logic stepEnd;
    logic periodEnd;

    // level, high for the whole final period of a step
    logic lastPeriod;

    modport timer (output stepStart, stepEnd, periodEnd, lastPeriod);

    modport seq (output step, input stepEnd);

    modport gen (input step, stepStart, stepEnd, periodEnd, lastPeriod);

endinterface

`default_nettype wire

// File: design/stepTimer.sv
`default_nettype none

`include "motoro3_cfg.svh"

module stepTimer (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    stepTiming_if.timer tim
);

    logic [`PERIOD_CNT_W-1:0] periodCnt;
    logic [`STEP_CNT_W-1:0]   periodInStep;
    logic                     periodEnd;
    logic                     lastPeriod;
    logic                     stepStart;
    logic                     stepEnd;

    // last cycle of each pwm period
    assign periodEnd = enable && (periodCnt == `PERIOD_CNT_W'(`PWM_PERIOD - 1));

    // final period of the step
    assign lastPeriod = enable && (periodInStep == `STEP_CNT_W'(`STEP_PERIODS - 1));

    assign stepEnd = periodEnd && lastPeriod;

    // both counters sit at zero on the first cycle of every step,
    // including the first cycle after enable rises
    assign stepStart = enable && (periodCnt == '0) && (periodInStep == '0);

    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            periodCnt    <= '0;
            periodInStep <= '0;
        end else if (periodEnd) begin
            periodCnt <= '0;
            if (lastPeriod) begin
                periodInStep <= '0;
            end else begin
                periodInStep <= periodInStep + 1'b1;
            end
        end else begin
            periodCnt <= periodCnt + 1'b1;
        end
    end

    assign tim.periodEnd  = periodEnd;
    assign tim.lastPeriod = lastPeriod;
    assign tim.stepStart  = stepStart;
    assign tim.stepEnd    = stepEnd;

endmodule

`default_nettype wire

// File: design/commutationSequencer.sv
`default_nettype none

module commutationSequencer (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    stepTiming_if.seq  seq,
    output logic [2:0] highSide
);
    import motoro3_pkg::*;

    stepIdx_t step;

    // high side for half of the turn, starting at the phase offset
    function automatic logic isHigh(stepIdx_t s, int unsigned offset);
        int unsigned rel;
        rel = (s + STEP_COUNT - offset) % STEP_COUNT;
        return rel < (STEP_COUNT / 2);
    endfunction

    // step register, wraps 11 -> 0 on the step end strobe
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            step <= '0;
        end else if (seq.stepEnd) begin
            if (step == LAST_STEP) begin
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    assign seq.step = step;

    // A at 0, B four steps later, C eight steps later
    assign highSide[0] = isHigh(step, 0);
    assign highSide[1] = isHigh(step, 4);
    assign highSide[2] = isHigh(step, 8);

endmodule

`default_nettype wire

// File: pwmgen/pwmGenerator.sv
`default_nettype none

`include "motoro3_cfg.svh"

module pwmGenerator #(
    parameter motoro3_pkg::phase_e PHASE = motoro3_pkg::PHASE_A
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    stepTiming_if.gen              tim,
    input  motoro3_pkg::pulseLen_t req,
    input  motoro3_pkg::pulseLen_t partnerSum,
    output motoro3_pkg::pulseLen_t pendingSum,
    output logic                   pwm,
    output motoro3_pkg::accum_t    lost
);
    import motoro3_pkg::*;

    localparam stepIdx_t  FORCE_STEP = forceStep(PHASE);
    localparam pulseLen_t MIN_LEN    = pulseLen_t'(`MIN_PULSE);
    localparam pulseLen_t MAX_LEN    = pulseLen_t'(`PWM_PERIOD);

    pulseLen_t               remainder;
    pulseLen_t               sum;
    pulseLen_t               emitLen;
    logic                    onForceStep;
    logic                    emit;
    logic [`PULSE_CNT_W-1:0] pulseCnt;

    accum_t wantAcc;
    accum_t realAcc;
    accum_t wantStep;
    accum_t realStep;
    accum_t diff;

    // carried remainder plus this period's request
    assign sum        = remainder + req;
    assign pendingSum = sum;

    assign onForceStep = (tim.step == FORCE_STEP);

    // emit when long enough, when flushing the last period of a normal step,
    // or when the partner phase would be driven at least as long anyway
    always_comb begin
        emit = 1'b0;
        if (sum >= MIN_LEN) begin
            emit = 1'b1;
        end else if (tim.lastPeriod && !onForceStep) begin
            emit = 1'b1;
        end else if (onForceStep && (partnerSum >= sum)) begin
            emit = 1'b1;
        end
    end

    // pulse length, capped at a full period
    always_comb begin
        emitLen = '0;
        if (emit) begin
            emitLen = (sum > MAX_LEN) ? MAX_LEN : sum;
        end
    end

    // remainder carry and pulse timer
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            remainder <= '0;
            pulseCnt  <= '0;
        end else if (tim.periodEnd) begin
            remainder <= emit ? '0 : sum;
            pulseCnt  <= emitLen[`PULSE_CNT_W-1:0];
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    // high from the cycle after period end for pulseCnt cycles
    assign pwm = enable && (pulseCnt != '0);

    // totals including the period being decided now
    assign wantStep = wantAcc + accum_t'(req);
    assign realStep = realAcc + accum_t'(emitLen);
    assign diff     = wantStep - realStep;

    // step-local accounting; driven cycles are counted as they are committed
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            wantAcc <= '0;
            realAcc <= '0;
            lost    <= '0;
        end else if (tim.stepEnd) begin
            wantAcc <= '0;
            realAcc <= '0;
            // magnitude of want - real
            if (diff[$bits(accum_t)-1]) begin
                lost <= -diff;
            end else begin
                lost <= diff;
            end
        end else if (tim.periodEnd) begin
            wantAcc <= wantStep;
            realAcc <= realStep;
        end
    end

endmodule

`default_nettype wire

// File: design/motoro3Top.sv
`default_nettype none

module motoro3Top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  motoro3_pkg::pulseLen_t reqA,
    input  motoro3_pkg::pulseLen_t reqB,
    input  motoro3_pkg::pulseLen_t reqC,
    output logic                   pwmA,
    output logic                   pwmB,
    output logic                   pwmC,
    output logic                   highA,
    output logic                   highB,
    output logic                   highC,
    output motoro3_pkg::stepIdx_t  step,
    output logic                   stepStart,
    output motoro3_pkg::accum_t    lostA,
    output motoro3_pkg::accum_t    lostB,
    output motoro3_pkg::accum_t    lostC
);
    import motoro3_pkg::*;

    stepTiming_if timing ();

    logic [2:0] highSide;
    pulseLen_t  pendingA;
    pulseLen_t  pendingB;
    pulseLen_t  pendingC;

    stepTimer stepTimer_inst (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .tim    (timing)
    );

    commutationSequencer commutationSequencer_inst (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .seq      (timing),
        .highSide (highSide)
    );

    // partner ring, A looks at B, B at C, C at A
    pwmGenerator #(.PHASE(PHASE_A)) genA (
        .clk (clk), .reset (reset), .enable (enable), .tim (timing),
        .req (reqA), .partnerSum (pendingB), .pendingSum (pendingA),
        .pwm (pwmA), .lost (lostA)
    );

    pwmGenerator #(.PHASE(PHASE_B)) genB (
        .clk (clk), .reset (reset), .enable (enable), .tim (timing),
        .req (reqB), .partnerSum (pendingC), .pendingSum (pendingB),
        .pwm (pwmB), .lost (lostB)
    );

    pwmGenerator #(.PHASE(PHASE_C)) genC (
        .clk (clk), .reset (reset), .enable (enable), .tim (timing),
        .req (reqC), .partnerSum (pendingA), .pendingSum (pendingC),
        .pwm (pwmC), .lost (lostC)
    );

    assign highA     = highSide[0];
    assign highB     = highSide[1];
    assign highC     = highSide[2];
    assign step      = timing.step;
    assign stepStart = timing.stepStart;

endmodule

`default_nettype wire

// File: sim/motoro3_props.sv
`default_nettype none

module motoro3_props (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic stepStart,
    input logic stepEnd,
    input logic periodEnd,
    input logic pwm
);
    timeunit 1ns;
    timeprecision 1ps;

    // step start strobe is a single cycle
    assert property (@(posedge clk) disable iff (reset) stepStart |=> !stepStart)
        else $error("stepStart held for more than one cycle");

    // a step ends on a period boundary and the next step starts right after
    assert property (@(posedge clk) disable iff (reset || !enable)
        stepEnd |-> periodEnd ##1 stepStart)
        else $error("stepEnd not on a period boundary or not followed by stepStart");

    // disabling the stage kills any pulse in flight
    assert property (@(posedge clk) disable iff (reset) !enable |=> !pwm)
        else $error("pwm high after enable was low");

endmodule

// strobe checks on the timer, output check on each generator
bind stepTimer motoro3_props timerProps (
    .clk (clk), .reset (reset), .enable (enable), .stepStart (stepStart),
    .stepEnd (stepEnd), .periodEnd (periodEnd), .pwm (1'b0)
);

bind pwmGenerator motoro3_props genProps (
    .clk (clk), .reset (reset), .enable (enable), .stepStart (1'b0),
    .stepEnd (1'b0), .periodEnd (1'b0), .pwm (pwm)
);

`default_nettype wire

// File: sim/motoro3Tb.sv
`default_nettype none

`include "motoro3_cfg.svh"

module motoro3Tb;
    timeunit 1ns;
    timeprecision 1ps;
    import motoro3_pkg::*;

    localparam int STEP_CYCLES = `PWM_PERIOD * `STEP_PERIODS;
    localparam int WAIT_LIMIT  = 2 * STEP_CYCLES;
    localparam int NUM_ROWS    = 6;
    localparam int FORCE_AT [3] = '{1, 6, 11};

    typedef struct packed {
        pulseLen_t  a;
        pulseLen_t  b;
        pulseLen_t  c;
        logic [7:0] steps;
        logic       rnd;
    } row_t;

    logic      clk;
    logic      reset;
    logic      enable;
    pulseLen_t reqA;
    pulseLen_t reqB;
    pulseLen_t reqC;
    logic      pwmA;
    logic      pwmB;
    logic      pwmC;
    logic      highA;
    logic      highB;
    logic      highC;
    stepIdx_t  step;
    logic      stepStart;
    accum_t    lostA;
    accum_t    lostB;
    accum_t    lostC;

    // values driven at the next falling edge
    logic        curReset;
    logic        curEnable;
    logic        randomReqs;
    pulseLen_t   curReq [3];
    logic [31:0] rngState;
    logic        sawStepStart;
    row_t        rows [NUM_ROWS];

    // reference model state, as seen after the coming rising edge
    int        cyc;
    stepIdx_t  mStep;
    pulseLen_t mRem [3];
    int        mPulse [3];
    accum_t    mWant [3];
    accum_t    mReal [3];
    accum_t    mLost [3];

    motoro3Top motoro3Top_inst (
        .clk (clk), .reset (reset), .enable (enable),
        .reqA (reqA), .reqB (reqB), .reqC (reqC),
        .pwmA (pwmA), .pwmB (pwmB), .pwmC (pwmC),
        .highA (highA), .highB (highB), .highC (highC),
        .step (step), .stepStart (stepStart),
        .lostA (lostA), .lostB (lostB), .lostC (lostC)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] nextRandom(logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // high side for six consecutive steps starting at the phase offset
    function automatic logic highExpected(stepIdx_t s, int offset);
        int k;
        for (k = 0; k < 6; k++) begin
            if ((offset + k) % 12 == int'(s)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic stopOnError();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkStep(string name, stepIdx_t expected, stepIdx_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkLost(string name, accum_t expected, accum_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic resetModel();
        int p;
        cyc   = 0;
        mStep = '0;
        for (p = 0; p < 3; p++) begin
            mRem[p]   = '0;
            mPulse[p] = 0;
            mWant[p]  = '0;
            mReal[p]  = '0;
            mLost[p]  = '0;
        end
    endtask

    task automatic advanceModel();
        pulseLen_t sums [3];
        pulseLen_t lens [3];
        logic      atPeriodEnd;
        logic      inLastPeriod;
        logic      atStepEnd;
        logic      onForce;
        logic      fire;
        accum_t    wantAll;
        accum_t    realAll;
        int        p;
        if (curReset || !curEnable) begin
            resetModel();
        end else begin
            atPeriodEnd  = (cyc % `PWM_PERIOD) == `PWM_PERIOD - 1;
            inLastPeriod = (cyc / `PWM_PERIOD) == `STEP_PERIODS - 1;
            atStepEnd    = (cyc == STEP_CYCLES - 1);
            for (p = 0; p < 3; p++) begin
                sums[p] = mRem[p] + curReq[p];
            end
            for (p = 0; p < 3; p++) begin
                onForce = (int'(mStep) == FORCE_AT[p]);
                // partner ring, A watches B, B watches C, C watches A
                fire = (sums[p] >= pulseLen_t'(`MIN_PULSE)) || (inLastPeriod && !onForce)
                    || (onForce && (sums[(p + 1) % 3] >= sums[p]));
                lens[p] = '0;
                if (fire) begin
                    lens[p] = (sums[p] > pulseLen_t'(`PWM_PERIOD)) ?
                        pulseLen_t'(`PWM_PERIOD) : sums[p];
                end
                if (atPeriodEnd) begin
                    mRem[p]   = fire ? '0 : sums[p];
                    mPulse[p] = int'(lens[p]);
                    wantAll   = mWant[p] + accum_t'(curReq[p]);
                    realAll   = mReal[p] + accum_t'(lens[p]);
                    if (atStepEnd) begin
                        mLost[p] = (wantAll >= realAll) ? wantAll - realAll : realAll - wantAll;
                        mWant[p] = '0;
                        mReal[p] = '0;
                    end else begin
                        mWant[p] = wantAll;
                        mReal[p] = realAll;
                    end
                end else if (mPulse[p] > 0) begin
                    mPulse[p]--;
                end
            end
            if (atStepEnd) begin
                mStep = (mStep == stepIdx_t'(11)) ? '0 : mStep + 4'd1;
            end
            cyc = (cyc + 1) % STEP_CYCLES;
        end
    endtask

    task automatic compareOutputs();
        checkBit("pwmA", enable && (mPulse[0] != 0), pwmA);
        checkBit("pwmB", enable && (mPulse[1] != 0), pwmB);
        checkBit("pwmC", enable && (mPulse[2] != 0), pwmC);
        checkBit("highA", highExpected(mStep, 0), highA);
        checkBit("highB", highExpected(mStep, 4), highB);
        checkBit("highC", highExpected(mStep, 8), highC);
        checkBit("stepStart", enable && (cyc == 0), stepStart);
        checkStep("step", mStep, step);
        checkLost("lostA", mLost[0], lostA);
        checkLost("lostB", mLost[1], lostB);
        checkLost("lostC", mLost[2], lostC);
        sawStepStart = stepStart;
    endtask

    // check on the falling edge, then drive the next inputs
    task automatic tick();
        int p;
        @(negedge clk);
        compareOutputs();
        if (randomReqs && (cyc % `PWM_PERIOD == 0)) begin
            for (p = 0; p < 3; p++) begin
                rngState  = nextRandom(rngState);
                curReq[p] = pulseLen_t'(rngState[5:0]);
            end
        end
        reset  = curReset;
        enable = curEnable;
        reqA   = curReq[0];
        reqB   = curReq[1];
        reqC   = curReq[2];
        advanceModel();
    endtask

    task automatic runCycles(int n);
        repeat (n) tick();
    endtask

    task automatic waitStepStart();
        int waited;
        waited       = 0;
        sawStepStart = 1'b0;
        while (!sawStepStart && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (!sawStepStart) begin
            $display("timeout: no stepStart seen within %0d cycles", WAIT_LIMIT);
            stopOnError();
        end
    endtask

    initial begin
        int r;
        clk          = 1'b0;
        reset        = 1'b1;
        enable       = 1'b0;
        reqA         = '0;
        reqB         = '0;
        reqC         = '0;
        curReset     = 1'b1;
        curEnable    = 1'b0;
        randomReqs   = 1'b0;
        curReq[0]    = '0;
        curReq[1]    = '0;
        curReq[2]    = '0;
        rngState     = 32'd47;
        sawStepStart = 1'b0;
        resetModel();

        // reqA, reqB, reqC, steps, random
        rows[0] = '{16'd20, 16'd12, 16'd40, 8'd13, 1'b0};
        rows[1] = '{16'd3, 16'd5, 16'd2, 8'd12, 1'b0};
        rows[2] = '{16'd70, 16'd64, 16'd65, 8'd2, 1'b0};
        rows[3] = '{16'd1, 16'd0, 16'd6, 8'd12, 1'b0};
        rows[4] = '{16'd0, 16'd0, 16'd0, 8'd12, 1'b1};
        rows[5] = '{16'd0, 16'd0, 16'd0, 8'd1, 1'b0};

        // reset is already high for the first edge
        runCycles(2);
        curReset = 1'b0;
        runCycles(4);
        curEnable = 1'b1;

        for (r = 0; r < NUM_ROWS; r++) begin
            curReq[0]  = rows[r].a;
            curReq[1]  = rows[r].b;
            curReq[2]  = rows[r].c;
            randomReqs = rows[r].rnd;
            repeat (int'(rows[r].steps)) waitStepStart();
        end
        randomReqs = 1'b0;

        // drop enable with remainders in flight, then restart
        curReq[0] = 16'd3;
        curReq[1] = 16'd3;
        curReq[2] = 16'd3;
        waitStepStart();
        runCycles(100);
        curEnable = 1'b0;
        runCycles(20);
        curEnable = 1'b1;
        repeat (3) waitStepStart();
        runCycles(2);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: motoro3.f
+incdir+common
common/motoro3_pkg.sv
common/stepTiming_if.sv
design/stepTimer.sv
design/commutationSequencer.sv
pwmgen/pwmGenerator.sv
design/motoro3Top.sv
sim/motoro3_props.sv
sim/motoro3Tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module motoro3Tb -f motoro3.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log \
    && echo "simulation run passed" \
    || { echo "simulation run failed"; exit 1; }
